/* tb.f */
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline_control.sv
source/cpu_core.sv
sim/tb_cpu_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cpu_core \
	-f tb.f \
	--Mdir obj_dir -o tb_cpu_core_sim

./obj_dir/tb_cpu_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* sim/tb_cpu_core.sv */
// Testbench for the CPU core with program ROM, instruction-set model and write-back checks
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;

	localparam logic [4:0] OPC_HALT = 5'b00000;
	localparam logic [4:0] OPC_NOP = 5'b00001;
	localparam logic [4:0] OPC_ADDI = 5'b01000;
	localparam logic [4:0] OPC_SUBI = 5'b01001;
	localparam logic [4:0] OPC_XORI = 5'b01010;
	localparam logic [4:0] OPC_ANDNI = 5'b01011;
	localparam logic [4:0] OPC_BEQZ = 5'b01100;
	localparam logic [4:0] OPC_BNEZ = 5'b01101;
	localparam logic [4:0] OPC_SLBI = 5'b10010;
	localparam logic [4:0] OPC_LBI = 5'b11000;
	localparam logic [4:0] OPC_RTYPE = 5'b11011;
	localparam int HALT_TIMEOUT = 2000;

	logic clk;
	logic rst;
	logic [15:0] imem_data;
	logic [15:0] imem_addr;
	logic wb_valid;
	logic [2:0] wb_reg;
	logic [15:0] wb_data;
	logic halted;
	logic err;

	logic [15:0] rom [0:255];
	int prog_len;
	logic [2:0] exp_reg_q [$];
	logic [15:0] exp_data_q [$];
	int model_writes;
	bit model_fault;
	int writes_seen;
	int errors;
	int tests_run;
	int tests_failed;
	integer seed;

	cpu_core UUT (
		.clk(clk), .rst(rst), .imem_data(imem_data), .imem_addr(imem_addr),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.halted(halted), .err(err)
	);

	// Instruction memory answers in the same cycle
	assign imem_data = rom[imem_addr[8:1]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [15:0] sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic logic [15:0] sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [4:0] op, input logic [2:0] rs,
			input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_byte(input logic [4:0] op, input logic [2:0] rs,
			input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] enc_reg(input logic [2:0] rs, input logic [2:0] rt,
			input logic [2:0] rd, input logic [1:0] fn);
		return {OPC_RTYPE, rs, rt, rd, fn};
	endfunction

	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		assert (cond) else begin
			$display("Check failed at %0t: %s", $time, what);
			errors++;
		end
	endtask

	// Every write-back strobe must match the oldest write of the model
	always @(posedge clk) begin
		if (!rst && wb_valid) begin
			writes_seen++;
			require(exp_reg_q.size() > 0, "write-back strobe after the last expected write");
			if (exp_reg_q.size() > 0) begin
				compare_value("wb_reg", 16'(wb_reg), 16'(exp_reg_q[0]));
				compare_value("wb_data", wb_data, exp_data_q[0]);
				void'(exp_reg_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	// Unused words decode as an illegal opcode
	task automatic clear_rom();
		for (int i = 0; i < 256; i++) begin
			rom[i[7:0]] = {8'hF8, i[7:0]};
		end
		prog_len = 0;
	endtask

	task automatic emit(input logic [15:0] word);
		rom[prog_len[7:0]] = word;
		prog_len++;
	endtask

	// Interprets the ROM from address 0 and queues the register writes in order
	task automatic build_model(output int n_writes, output bit faulted);
		logic [15:0] regs [0:7];
		logic [15:0] pc;
		logic [15:0] w;
		logic [15:0] res;
		logic [4:0] op;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] dst;
		bit done;
		int steps;
		for (int i = 0; i < 8; i++) begin
			regs[i[2:0]] = '0;
		end
		exp_reg_q.delete();
		exp_data_q.delete();
		n_writes = 0;
		faulted = 1'b0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			w = rom[pc[8:1]];
			op = w[15:11];
			rs = w[10:8];
			rt = w[7:5];
			pc = pc + 16'd2;
			res = '0;
			dst = rt;
			case (op)
				OPC_HALT: done = 1'b1;
				OPC_NOP: res = '0;
				OPC_ADDI: res = regs[rs] + sext5(w[4:0]);
				OPC_SUBI: res = sext5(w[4:0]) - regs[rs];
				OPC_XORI: res = regs[rs] ^ {11'd0, w[4:0]};
				OPC_ANDNI: res = regs[rs] & ~{11'd0, w[4:0]};
				OPC_BEQZ: if (regs[rs] == 16'd0) pc = pc + sext8(w[7:0]);
				OPC_BNEZ: if (regs[rs] != 16'd0) pc = pc + sext8(w[7:0]);
				OPC_LBI: begin
					res = sext8(w[7:0]);
					dst = rs;
				end
				OPC_SLBI: begin
					res = {regs[rs][7:0], w[7:0]};
					dst = rs;
				end
				OPC_RTYPE: begin
					dst = w[4:2];
					case (w[1:0])
						2'b00: res = regs[rs] + regs[rt];
						2'b01: res = regs[rt] - regs[rs];
						2'b10: res = regs[rs] ^ regs[rt];
						default: res = regs[rs] & ~regs[rt];
					endcase
				end
				default: begin
					done = 1'b1;
					faulted = 1'b1;
				end
			endcase
			if (op inside {OPC_ADDI, OPC_SUBI, OPC_XORI, OPC_ANDNI, OPC_LBI, OPC_SLBI,
					OPC_RTYPE}) begin
				regs[dst] = res;
				exp_reg_q.push_back(dst);
				exp_data_q.push_back(res);
				n_writes++;
			end
			steps++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (8) begin
			@(negedge clk);
			compare_value("imem_addr", imem_addr, 16'd0);
			compare_value("wb_valid", 16'(wb_valid), 16'd0);
			compare_value("halted", 16'(halted), 16'd0);
			compare_value("err", 16'(err), 16'd0);
		end
		rst = 1'b0;
	endtask

	task automatic start_program();
		build_model(model_writes, model_fault);
		writes_seen = 0;
		apply_reset();
		// First instruction is still two cycles from write-back
		repeat (2) begin
			@(negedge clk);
			compare_value("wb_valid", 16'(wb_valid), 16'd0);
			compare_value("halted", 16'(halted), 16'd0);
			compare_value("err", 16'(err), 16'd0);
		end
	endtask

	task automatic finish_program();
		int cycles;
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
		// Core must stay stopped with no further writes
		repeat (8) begin
			@(negedge clk);
			compare_value("halted", 16'(halted), 16'd1);
			compare_value("err", 16'(err), 16'(model_fault));
		end
		compare_value("write count", 16'(writes_seen), 16'(model_writes));
		require(exp_reg_q.size() == 0, "some expected writes never appeared");
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
	endtask

	task automatic random_imm_program();
		logic [2:0] ra;
		logic [2:0] rb;
		logic [7:0] imm;
		int kind;
		clear_rom();
		for (int i = 0; i < 24; i++) begin
			ra = 3'($random(seed));
			rb = 3'($random(seed));
			imm = 8'($random(seed));
			kind = $unsigned($random(seed)) % 6;
			case (kind)
				0: emit(enc_byte(OPC_LBI, ra, imm));
				1: emit(enc_byte(OPC_SLBI, ra, imm));
				2: emit(enc_imm(OPC_ADDI, ra, rb, imm[4:0]));
				3: emit(enc_imm(OPC_SUBI, ra, rb, imm[4:0]));
				4: emit(enc_imm(OPC_XORI, ra, rb, imm[4:0]));
				default: emit(enc_imm(OPC_ANDNI, ra, rb, imm[4:0]));
			endcase
		end
		emit(enc_byte(OPC_HALT, 3'd0, 8'd0));
	endtask

	task automatic dependent_rtype_program();
		logic [2:0] prev;
		logic [2:0] older;
		logic [2:0] rd;
		clear_rom();
		for (int r = 1; r < 5; r++) begin
			emit(enc_byte(OPC_LBI, 3'(r), 8'($random(seed))));
		end
		prev = 3'd1;
		older = 3'd2;
		for (int i = 0; i < 16; i++) begin
			rd = 3'($random(seed));
			// Rs comes from the result in execute and Rt from the one in write-back
			emit(enc_reg(prev, older, rd, 2'(i)));
			older = prev;
			prev = rd;
		end
		emit(enc_byte(OPC_HALT, 3'd0, 8'd0));
	endtask

	task automatic branch_program();
		clear_rom();
		emit(enc_byte(OPC_LBI, 3'd1, 8'd0));
		emit(enc_byte(OPC_LBI, 3'd2, 8'd5));
		// Taken branches skip the marker write after them
		emit(enc_byte(OPC_BEQZ, 3'd1, 8'd2));
		emit(enc_byte(OPC_LBI, 3'd7, 8'h55));
		emit(enc_byte(OPC_BNEZ, 3'd2, 8'd2));
		emit(enc_byte(OPC_LBI, 3'd7, 8'h66));
		emit(enc_byte(OPC_BEQZ, 3'd2, 8'd4));
		emit(enc_byte(OPC_LBI, 3'd3, 8'h11));
		emit(enc_byte(OPC_BNEZ, 3'd1, 8'd4));
		emit(enc_byte(OPC_LBI, 3'd4, 8'h22));
		// Countdown loop whose branch tests the value still in execute
		emit(enc_byte(OPC_LBI, 3'd5, 8'd3));
		emit(enc_imm(OPC_ADDI, 3'd5, 3'd5, 5'h1F));
		emit(enc_byte(OPC_BNEZ, 3'd5, 8'hFC));
		emit(enc_byte(OPC_LBI, 3'd6, 8'd0));
		emit(enc_byte(OPC_BEQZ, 3'd6, 8'd2));
		emit(enc_byte(OPC_LBI, 3'd7, 8'h77));
		emit(enc_byte(OPC_LBI, 3'd6, 8'h33));
		emit(enc_byte(OPC_HALT, 3'd0, 8'd0));
	endtask

	task automatic halt_program();
		clear_rom();
		emit(enc_byte(OPC_LBI, 3'd1, 8'h40));
		emit(enc_imm(OPC_ADDI, 3'd1, 3'd2, 5'd3));
		emit(enc_imm(OPC_XORI, 3'd2, 3'd3, 5'h1F));
		emit(enc_byte(OPC_HALT, 3'd0, 8'd0));
		// Never executed
		emit(enc_byte(OPC_LBI, 3'd1, 8'h99));
		emit(enc_byte(OPC_LBI, 3'd2, 8'h98));
		emit(enc_imm(OPC_ADDI, 3'd3, 3'd3, 5'd1));
	endtask

	task automatic illegal_program();
		clear_rom();
		emit(enc_byte(OPC_LBI, 3'd1, 8'h12));
		emit(enc_byte(OPC_SLBI, 3'd1, 8'h34));
		emit(enc_imm(OPC_SUBI, 3'd1, 3'd2, 5'd7));
		emit({5'b10000, 11'd0});
		emit(enc_byte(OPC_LBI, 3'd3, 8'h56));
		emit(enc_byte(OPC_LBI, 3'd4, 8'h78));
	endtask

	initial begin
		int mark;
		seed = 32'h623b905c;
		rst = 1'b1;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		writes_seen = 0;
		clear_rom();

		mark = errors;
		random_imm_program();
		start_program();
		report_test("reset state", mark);
		mark = errors;
		finish_program();
		report_test("random immediate and byte loads", mark);

		mark = errors;
		dependent_rtype_program();
		start_program();
		finish_program();
		report_test("dependent register forms", mark);

		mark = errors;
		branch_program();
		start_program();
		finish_program();
		report_test("taken and untaken branches", mark);

		mark = errors;
		halt_program();
		start_program();
		finish_program();
		report_test("halt", mark);

		mark = errors;
		illegal_program();
		start_program();
		finish_program();
		report_test("illegal opcode", mark);

		$display("tests %0d, failed %0d, failed checks %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/cpu_core.sv */
// CPU core: four-stage pipeline with external instruction memory
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_core (
	input wire clk,
	input wire rst,
	input wire [`CPU_WORD_W-1:0] imem_data,
	output logic [`CPU_WORD_W-1:0] imem_addr,
	output logic wb_valid,
	output logic [`CPU_REG_W-1:0] wb_reg,
	output logic [`CPU_WORD_W-1:0] wb_data,
	output logic halted,
	output logic err
);
	import cpu_pkg::*;

	logic [`CPU_WORD_W-1:0] dec_instr;
	logic [`CPU_WORD_W-1:0] dec_pc_next;
	logic branch_taken;
	logic [`CPU_WORD_W-1:0] branch_target;
	logic freeze;
	logic squash;
	logic [`CPU_REG_W-1:0] src_rs;
	logic [`CPU_REG_W-1:0] src_rt;
	logic uses_rs;
	logic uses_rt;
	logic halt_req;
	logic illegal;
	logic fwd_rs_ex;
	logic fwd_rt_ex;
	logic [`CPU_WORD_W-1:0] rf_a;
	logic [`CPU_WORD_W-1:0] rf_b;
	logic [`CPU_WORD_W-1:0] exe_a;
	logic [`CPU_WORD_W-1:0] exe_b;
	alu_op_t exe_op;
	logic [`CPU_REG_W-1:0] exe_dest;
	logic exe_write;
	logic [`CPU_WORD_W-1:0] ex_result;
	logic [`CPU_REG_W-1:0] ex_dest;
	logic ex_write;

	// Branch flush comes straight from decode
	fetch_stage u_fetch (
		.clk(clk), .rst(rst), .imem_data(imem_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.freeze(freeze), .flush(branch_taken),
		.imem_addr(imem_addr), .dec_instr(dec_instr), .dec_pc_next(dec_pc_next)
	);

	reg_file u_rf (
		.clk(clk), .rst(rst), .rd_sel_a(src_rs), .rd_sel_b(src_rt),
		.wr_sel(wb_reg), .wr_data(wb_data), .wr_en(wb_valid),
		.rd_data_a(rf_a), .rd_data_b(rf_b)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst), .instr(dec_instr), .pc_next(dec_pc_next),
		.rf_a(rf_a), .rf_b(rf_b), .ex_result(ex_result),
		.fwd_rs_ex(fwd_rs_ex), .fwd_rt_ex(fwd_rt_ex), .squash(squash),
		.src_rs(src_rs), .src_rt(src_rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
		.halt_req(halt_req), .illegal(illegal),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.exe_a(exe_a), .exe_b(exe_b), .exe_op(exe_op),
		.exe_dest(exe_dest), .exe_write(exe_write)
	);

	execute_stage u_execute (
		.clk(clk), .rst(rst), .a(exe_a), .b(exe_b), .op(exe_op),
		.dest(exe_dest), .write(exe_write),
		.ex_result(ex_result), .ex_dest(ex_dest), .ex_write(ex_write),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	pipeline_control u_control (
		.clk(clk), .rst(rst), .src_rs(src_rs), .src_rt(src_rt),
		.uses_rs(uses_rs), .uses_rt(uses_rt),
		.ex_dest(ex_dest), .ex_write(ex_write),
		.halt_req(halt_req), .illegal(illegal),
		.fwd_rs_ex(fwd_rs_ex), .fwd_rt_ex(fwd_rt_ex),
		.freeze(freeze), .squash(squash), .halted(halted), .err(err)
	);

endmodule

`default_nettype wire

/* source/pipeline_control.sv */
// Pipeline control: forwarding selects and the run/halt/fault state machine
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module pipeline_control (
	input wire clk,
	input wire rst,
	input wire [`CPU_REG_W-1:0] src_rs,
	input wire [`CPU_REG_W-1:0] src_rt,
	input wire uses_rs,
	input wire uses_rt,
	input wire [`CPU_REG_W-1:0] ex_dest,
	input wire ex_write,
	input wire halt_req,
	input wire illegal,
	output logic fwd_rs_ex,
	output logic fwd_rt_ex,
	output logic freeze,
	output logic squash,
	output logic halted,
	output logic err
);
	import cpu_pkg::*;

	ctl_state_t state;
	ctl_state_t state_next;

	// Execute holds the only in-flight result not yet in the register file
	assign fwd_rs_ex = uses_rs && ex_write && (ex_dest == src_rs);
	assign fwd_rt_ex = uses_rt && ex_write && (ex_dest == src_rt);

	always_comb begin
		state_next = state;
		if (state == CTL_RUN) begin
			if (illegal) begin
				state_next = CTL_FAULT;
			end else if (halt_req) begin
				state_next = CTL_HALTED;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CTL_RUN;
		end else begin
			state <= state_next;
		end
	end

	// Stop fetch from the stopping instruction on
	assign squash = halt_req || illegal;
	assign freeze = squash || (state != CTL_RUN);

	assign halted = (state != CTL_RUN);
	assign err = (state == CTL_FAULT);

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// Execute stage: ALU and the execute/write-back register
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module execute_stage (
	input wire clk,
	input wire rst,
	input wire [`CPU_WORD_W-1:0] a,
	input wire [`CPU_WORD_W-1:0] b,
	input wire cpu_pkg::alu_op_t op,
	input wire [`CPU_REG_W-1:0] dest,
	input wire write,
	output logic [`CPU_WORD_W-1:0] ex_result,
	output logic [`CPU_REG_W-1:0] ex_dest,
	output logic ex_write,
	output logic wb_valid,
	output logic [`CPU_REG_W-1:0] wb_reg,
	output logic [`CPU_WORD_W-1:0] wb_data
);
	import cpu_pkg::*;

	// Combinational so decode can forward it in the same cycle
	always_comb begin
		case (op)
			ALU_ADD: ex_result = a + b;
			ALU_SUB_FROM: ex_result = b - a;
			ALU_XOR: ex_result = a ^ b;
			ALU_ANDN: ex_result = a & ~b;
			ALU_SHIFT_BYTE_IN: ex_result = {a[7:0], b[7:0]};
			default: ex_result = b;
		endcase
	end

	assign ex_dest = dest;
	assign ex_write = write;

	// Write-back register, strobe is one cycle per write
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_reg <= '0;
		end else begin
			wb_valid <= write;
			wb_reg <= dest;
		end
		wb_data <= ex_result;
	end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// Decode stage: field decode, operand forwarding, branch resolve, decode/execute register
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module decode_stage (
	input wire clk,
	input wire rst,
	input wire [`CPU_WORD_W-1:0] instr,
	input wire [`CPU_WORD_W-1:0] pc_next,
	input wire [`CPU_WORD_W-1:0] rf_a,
	input wire [`CPU_WORD_W-1:0] rf_b,
	input wire [`CPU_WORD_W-1:0] ex_result,
	input wire fwd_rs_ex,
	input wire fwd_rt_ex,
	input wire squash,
	output logic [`CPU_REG_W-1:0] src_rs,
	output logic [`CPU_REG_W-1:0] src_rt,
	output logic uses_rs,
	output logic uses_rt,
	output logic halt_req,
	output logic illegal,
	output logic branch_taken,
	output logic [`CPU_WORD_W-1:0] branch_target,
	output logic [`CPU_WORD_W-1:0] exe_a,
	output logic [`CPU_WORD_W-1:0] exe_b,
	output cpu_pkg::alu_op_t exe_op,
	output logic [`CPU_REG_W-1:0] exe_dest,
	output logic exe_write
);
	import cpu_pkg::*;

	opcode_t opcode;
	alu_op_t alu_op;
	logic [`CPU_WORD_W-1:0] op_a;
	logic [`CPU_WORD_W-1:0] op_b;
	logic [`CPU_WORD_W-1:0] second;
	logic [`CPU_WORD_W-1:0] imm_sext5;
	logic [`CPU_WORD_W-1:0] imm_zext5;
	logic [`CPU_WORD_W-1:0] imm_sext8;
	logic [`CPU_WORD_W-1:0] imm_zext8;
	logic [`CPU_REG_W-1:0] dest;
	logic dest_write;
	logic rs_zero;

	assign opcode = opcode_t'(instr[15:11]);
	assign src_rs = instr[10:8];
	assign src_rt = instr[7:5];

	assign imm_sext5 = {{(`CPU_WORD_W-5){instr[4]}}, instr[4:0]};
	assign imm_zext5 = {{(`CPU_WORD_W-5){1'b0}}, instr[4:0]};
	assign imm_sext8 = {{(`CPU_WORD_W-8){instr[7]}}, instr[7:0]};
	assign imm_zext8 = {{(`CPU_WORD_W-8){1'b0}}, instr[7:0]};

	// Execute result wins over the register file
	assign op_a = fwd_rs_ex ? ex_result : rf_a;
	assign op_b = fwd_rt_ex ? ex_result : rf_b;

	assign rs_zero = (op_a == '0);
	assign branch_target = pc_next + imm_sext8;

	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		halt_req = 1'b0;
		illegal = 1'b0;
		branch_taken = 1'b0;
		alu_op = ALU_PASS_B;
		second = op_b;
		// Immediate ALU forms write the register in bits 7 to 5
		dest = instr[7:5];
		dest_write = 1'b0;
		case (opcode)
			OP_HALT: halt_req = 1'b1;
			OP_NOP: begin
				// Bubble, nothing to do
			end
			OP_ADDI, OP_SUBI: begin
				uses_rs = 1'b1;
				alu_op = (opcode == OP_ADDI) ? ALU_ADD : ALU_SUB_FROM;
				second = imm_sext5;
				dest_write = 1'b1;
			end
			OP_XORI, OP_ANDNI: begin
				uses_rs = 1'b1;
				alu_op = (opcode == OP_XORI) ? ALU_XOR : ALU_ANDN;
				second = imm_zext5;
				dest_write = 1'b1;
			end
			OP_RTYPE: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				dest = instr[4:2];
				dest_write = 1'b1;
				case (instr[1:0])
					2'b00: alu_op = ALU_ADD;
					2'b01: alu_op = ALU_SUB_FROM;
					2'b10: alu_op = ALU_XOR;
					2'b11: alu_op = ALU_ANDN;
				endcase
			end
			OP_LBI: begin
				second = imm_sext8;
				dest = instr[10:8];
				dest_write = 1'b1;
			end
			OP_SLBI: begin
				uses_rs = 1'b1;
				alu_op = ALU_SHIFT_BYTE_IN;
				second = imm_zext8;
				dest = instr[10:8];
				dest_write = 1'b1;
			end
			OP_BEQZ: begin
				uses_rs = 1'b1;
				branch_taken = rs_zero;
			end
			OP_BNEZ: begin
				uses_rs = 1'b1;
				branch_taken = !rs_zero;
			end
			default: illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || squash) begin
			exe_op <= ALU_PASS_B;
			exe_dest <= '0;
			exe_write <= 1'b0;
		end else begin
			exe_op <= alu_op;
			exe_dest <= dest;
			exe_write <= dest_write;
		end
		exe_a <= op_a;
		exe_b <= second;
	end

endmodule

`default_nettype wire

/* source/reg_file.sv */
// Register file: eight 16-bit registers, two read ports, write-before-read bypass
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module reg_file (
	input wire clk,
	input wire rst,
	input wire [`CPU_REG_W-1:0] rd_sel_a,
	input wire [`CPU_REG_W-1:0] rd_sel_b,
	input wire [`CPU_REG_W-1:0] wr_sel,
	input wire [`CPU_WORD_W-1:0] wr_data,
	input wire wr_en,
	output logic [`CPU_WORD_W-1:0] rd_data_a,
	output logic [`CPU_WORD_W-1:0] rd_data_b
);

	logic [`CPU_WORD_W-1:0] regs [0:`CPU_NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Same-cycle write shows up on the read ports
	assign rd_data_a = (wr_en && wr_sel == rd_sel_a) ? wr_data : regs[rd_sel_a];
	assign rd_data_b = (wr_en && wr_sel == rd_sel_b) ? wr_data : regs[rd_sel_b];

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
// Fetch stage: PC register, next-PC select and the fetch/decode register
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module fetch_stage (
	input wire clk,
	input wire rst,
	input wire [`CPU_WORD_W-1:0] imem_data,
	input wire branch_taken,
	input wire [`CPU_WORD_W-1:0] branch_target,
	input wire freeze,
	input wire flush,
	output logic [`CPU_WORD_W-1:0] imem_addr,
	output logic [`CPU_WORD_W-1:0] dec_instr,
	output logic [`CPU_WORD_W-1:0] dec_pc_next
);

	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] pc_plus;

	assign pc_plus = pc + `CPU_PC_STEP;
	assign imem_addr = pc;

	// Hold on halt, else redirect on a taken branch
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (freeze) begin
			pc <= pc;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else begin
			pc <= pc_plus;
		end
	end

	// Wrong-path or post-halt fetch turns into a bubble
	always_ff @(posedge clk) begin
		if (rst || flush || freeze) begin
			dec_instr <= `CPU_NOP_WORD;
		end else begin
			dec_instr <= imem_data;
		end
		dec_pc_next <= pc_plus;
	end

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
// CPU package: opcode, ALU operation and control-state types
`default_nettype none

package cpu_pkg;

	// Major opcodes, instruction bits 15 to 11
	typedef enum logic [4:0] {
		OP_HALT  = 5'b00000,
		OP_NOP   = 5'b00001,
		OP_ADDI  = 5'b01000,
		OP_SUBI  = 5'b01001,
		OP_XORI  = 5'b01010,
		OP_ANDNI = 5'b01011,
		OP_BEQZ  = 5'b01100,
		OP_BNEZ  = 5'b01101,
		OP_SLBI  = 5'b10010,
		OP_LBI   = 5'b11000,
		OP_RTYPE = 5'b11011
	} opcode_t;

	// Operations carried from decode into execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB_FROM,       // second operand minus first
		ALU_XOR,
		ALU_ANDN,
		ALU_PASS_B,
		ALU_SHIFT_BYTE_IN
	} alu_op_t;

	// Run state of the core
	typedef enum logic [1:0] {
		CTL_RUN,
		CTL_HALTED,
		CTL_FAULT
	} ctl_state_t;

endpackage

`default_nettype wire

/* source/cpu_macros.svh */
// CPU macros: word and register-file widths, PC step and the bubble encoding
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and address width
`define CPU_WORD_W 16

// Register index width and register count
`define CPU_REG_W 3
`define CPU_NUM_REGS 8

// Instructions are two bytes wide
`define CPU_PC_STEP 16'd2

// NOP with all operand fields zero
`define CPU_NOP_WORD 16'h0800

`endif
